//--- sources.f
+incdir+hw
hw/rv_ctrl_pkg.sv
hw/exec_decoder.sv
hw/mem_decoder.sv
hw/flow_decoder.sv
hw/control_unit.sv
bench/control_unit_assert.sv
bench/control_unit_tb.sv

//--- Bender.yml
package:
  name: control_unit

export_include_dirs:
  - hw

sources:
  - files:
      - hw/rv_ctrl_pkg.sv
      - hw/exec_decoder.sv
      - hw/mem_decoder.sv
      - hw/flow_decoder.sv
      - hw/control_unit.sv
  - target: simulation
    files:
      - bench/control_unit_assert.sv
      - bench/control_unit_tb.sv

//--- bench/control_unit_tb.sv
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module control_unit_tb;

    localparam int CLK_PERIOD = 40;
    localparam int WAIT_LIMIT = 20;

    logic                    clk;
    logic                    rst;
    logic [`RV_XLEN-1:0]     instr;
    logic                    instr_valid;
    rv_ctrl_pkg::ctrl_word_t ctrl;
    logic                    ctrl_valid;

    // Stimulus table
    string                   names[$];
    logic [`RV_XLEN-1:0]     templates[$];
    rv_ctrl_pkg::ctrl_word_t expected[$];

    logic [31:0] rng_state;
    int          errors;
    int          checks;

    control_unit control_unit_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // X bits of a template are rd, rs1, rs2 or immediate bits
    function automatic logic [31:0] fill_template(input logic [31:0] tmpl,
                                                  input logic [31:0] rnd);
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            w[b] = (tmpl[b] === 1'bx) ? rnd[b] : tmpl[b];
        end
        return w;
    endfunction

    task automatic add_case(input string name, input logic [6:0] opcode, input logic [2:0] f3,
                            input logic [6:0] f7, input logic [22:0] word);
        names.push_back(name);
        templates.push_back({f7, 10'bx, f3, 5'bx, opcode});
        expected.push_back(word);
    endtask

    task automatic build_table();
        // Word: src_alu_ld_wr_osel_br_size_men_sx_mw_link_auipc_jalr_jal
        add_case("ADD",   `RV_OP_REG,    3'b000, 7'h00, 23'b10_0010_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("SUB",   `RV_OP_REG,    3'b000, 7'h20, 23'b10_0011_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("SLL",   `RV_OP_REG,    3'b001, 7'h00, 23'b10_0101_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("SLT",   `RV_OP_REG,    3'b010, 7'h00, 23'b10_1000_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("SLTU",  `RV_OP_REG,    3'b011, 7'h00, 23'b10_1001_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("XOR",   `RV_OP_REG,    3'b100, 7'h00, 23'b10_1100_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("SRL",   `RV_OP_REG,    3'b101, 7'h00, 23'b10_0110_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("SRA",   `RV_OP_REG,    3'b101, 7'h20, 23'b10_0111_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("OR",    `RV_OP_REG,    3'b110, 7'h00, 23'b10_1011_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("AND",   `RV_OP_REG,    3'b111, 7'h00, 23'b10_1010_0_1_000_000_00_0_0_0_0_0_0_0);
        add_case("ADDI",  `RV_OP_IMM,    3'b000, 7'bx,  23'b01_0010_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("SLLI",  `RV_OP_IMM,    3'b001, 7'h00, 23'b01_0101_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("SLTI",  `RV_OP_IMM,    3'b010, 7'bx,  23'b01_1000_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("SLTIU", `RV_OP_IMM,    3'b011, 7'bx,  23'b01_1001_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("XORI",  `RV_OP_IMM,    3'b100, 7'bx,  23'b01_1100_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("SRLI",  `RV_OP_IMM,    3'b101, 7'h00, 23'b01_0110_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("SRAI",  `RV_OP_IMM,    3'b101, 7'h20, 23'b01_0111_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("ORI",   `RV_OP_IMM,    3'b110, 7'bx,  23'b01_1011_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("ANDI",  `RV_OP_IMM,    3'b111, 7'bx,  23'b01_1010_0_1_001_000_00_0_0_0_0_0_0_0);
        add_case("LB",    `RV_OP_LOAD,   3'b000, 7'bx,  23'b01_0010_1_1_001_000_00_1_1_0_0_0_0_0);
        add_case("LH",    `RV_OP_LOAD,   3'b001, 7'bx,  23'b01_0010_1_1_001_000_01_1_1_0_0_0_0_0);
        add_case("LW",    `RV_OP_LOAD,   3'b010, 7'bx,  23'b01_0010_1_1_001_000_10_1_0_0_0_0_0_0);
        add_case("LBU",   `RV_OP_LOAD,   3'b100, 7'bx,  23'b01_0010_1_1_001_000_00_1_0_0_0_0_0_0);
        add_case("LHU",   `RV_OP_LOAD,   3'b101, 7'bx,  23'b01_0010_1_1_001_000_01_1_0_0_0_0_0_0);
        add_case("SB",    `RV_OP_STORE,  3'b000, 7'bx,  23'b10_0010_0_0_010_000_00_1_0_1_0_0_0_0);
        add_case("SH",    `RV_OP_STORE,  3'b001, 7'bx,  23'b10_0010_0_0_010_000_01_1_0_1_0_0_0_0);
        add_case("SW",    `RV_OP_STORE,  3'b010, 7'bx,  23'b10_0010_0_0_010_000_10_1_0_1_0_0_0_0);
        add_case("BEQ",   `RV_OP_BRANCH, 3'b000, 7'bx,  23'b10_0011_0_0_000_010_00_0_0_0_0_0_0_0);
        add_case("BNE",   `RV_OP_BRANCH, 3'b001, 7'bx,  23'b10_0011_0_0_000_001_00_0_0_0_0_0_0_0);
        add_case("BLT",   `RV_OP_BRANCH, 3'b100, 7'bx,  23'b10_0011_0_0_000_100_00_0_0_0_0_0_0_0);
        add_case("BGE",   `RV_OP_BRANCH, 3'b101, 7'bx,  23'b10_0011_0_0_000_101_00_0_0_0_0_0_0_0);
        add_case("BLTU",  `RV_OP_BRANCH, 3'b110, 7'bx,  23'b10_0011_0_0_000_110_00_0_0_0_0_0_0_0);
        add_case("BGEU",  `RV_OP_BRANCH, 3'b111, 7'bx,  23'b10_0011_0_0_000_111_00_0_0_0_0_0_0_0);
        add_case("LUI",   `RV_OP_LUI,    3'bx,   7'bx,  23'b00_0000_0_1_011_000_00_0_0_0_0_0_0_0);
        add_case("AUIPC", `RV_OP_AUIPC,  3'bx,   7'bx,  23'b00_0010_0_1_011_000_00_0_0_0_0_1_0_0);
        add_case("JAL",   `RV_OP_JAL,    3'bx,   7'bx,  23'b00_0000_0_1_000_000_00_0_0_0_1_0_0_1);
        add_case("JALR",  `RV_OP_JALR,   3'b000, 7'bx,  23'b01_0100_0_1_001_000_00_0_0_0_1_0_1_0);
        // Encodings outside the kept set decode to zero
        add_case("MUL",   `RV_OP_REG,    3'b000, 7'h01, 23'b0);
        add_case("DIVU",  `RV_OP_REG,    3'b101, 7'h01, 23'b0);
        add_case("SRI_F7", `RV_OP_IMM,   3'b101, 7'h01, 23'b0);
        add_case("LD_011", `RV_OP_LOAD,  3'b011, 7'bx,  23'b0);
        add_case("ST_100", `RV_OP_STORE, 3'b100, 7'bx,  23'b0);
        add_case("BR_010", `RV_OP_BRANCH, 3'b010, 7'bx, 23'b0);
        add_case("FENCE", 7'b0001111,    3'bx,   7'bx,  23'b0);
        add_case("SYSTEM", 7'b1110011,   3'bx,   7'bx,  23'b0);
    endtask

    task automatic check_output(input string name, input logic exp_valid, input bit compare_word,
                                input rv_ctrl_pkg::ctrl_word_t exp_ctrl);
        checks++;
        if (ctrl_valid !== exp_valid) begin
            errors++;
            $display("** Error %s: ctrl_valid expected %0b actual %0b", name, exp_valid, ctrl_valid);
        end else if (compare_word && ctrl !== exp_ctrl) begin
            errors++;
            $display("** Error %s: ctrl expected %b actual %b", name, exp_ctrl, ctrl);
        end
    endtask

    // Counts falling edges until ctrl_valid rises
    task automatic wait_ctrl_valid(output int edges, output bit timed_out);
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!ctrl_valid && edges < WAIT_LIMIT);
        timed_out = !ctrl_valid;
    endtask

    initial begin
        int  edges;
        bit  timed_out;
        bit  prev_valid;
        bit  cur_valid;
        int  prev_idx;
        int  cur_idx;
        int  idx;
        int  slot;

        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        rng_state   = 32'd19976;
        errors      = 0;
        checks      = 0;
        build_table();

        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_output("RESET", 1'b0, 1'b1, '0);
        @(posedge clk);
        @(negedge clk);
        check_output("IDLE", 1'b0, 1'b1, '0);  // Opcode 0 keeps ctrl at zero

        // First instruction alone, to measure the latency
        @(posedge clk);
        rng_state = xorshift32(rng_state);
        instr       <= fill_template(templates[0], rng_state);
        instr_valid <= 1'b1;
        wait_ctrl_valid(edges, timed_out);
        if (timed_out) begin
            errors++;
            $display("Timed out waiting for ctrl_valid after the first instruction");
        end else begin
            if (edges != 2) begin
                errors++;
                $display("** Error LATENCY: falling edges expected 2 actual %0d", edges);
            end
            check_output(names[0], 1'b1, 1'b1, expected[0]);

            // Back to back, with an idle slot now and then
            prev_valid = 1'b1;
            prev_idx   = 0;
            cur_idx    = 0;
            idx        = 1;
            slot       = 0;
            while (idx < names.size() || prev_valid) begin
                @(posedge clk);
                rng_state = xorshift32(rng_state);
                slot++;
                if (idx < names.size() && slot % 6 != 0) begin
                    instr       <= fill_template(templates[idx], rng_state);
                    instr_valid <= 1'b1;
                    cur_valid = 1'b1;
                    cur_idx   = idx;
                    idx++;
                end else begin
                    instr       <= rng_state;
                    instr_valid <= 1'b0;
                    cur_valid = 1'b0;
                end
                @(negedge clk);
                if (prev_valid) begin
                    check_output(names[prev_idx], 1'b1, 1'b1, expected[prev_idx]);
                end else begin
                    check_output("GAP", 1'b0, 1'b0, '0);
                end
                prev_valid = cur_valid;
                prev_idx   = cur_idx;
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/control_unit_assert.sv
`timescale 1ns/1ps

module control_unit_assert (
    input logic                    clk,
    input logic                    rst,
    input rv_ctrl_pkg::ctrl_word_t ctrl,
    input logic                    ctrl_valid
);

    a_reset_clears_valid: assert property (@(posedge clk) rst |=> !ctrl_valid)
        else $error("ctrl_valid high in the cycle after reset");

    // Stores always enable memory
    a_write_needs_enable: assert property (@(posedge clk) disable iff (rst)
        ctrl.mem_write |-> ctrl.mem_enable)
        else $error("mem_write without mem_enable");

    a_no_store_writeback: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.rf_write && ctrl.mem_write))
        else $error("rf_write and mem_write both high");

    a_one_jump_kind: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.jal && ctrl.jalr))
        else $error("jal and jalr both high");

    a_branch_no_writeback: assert property (@(posedge clk) disable iff (rst)
        (ctrl.branch_type != 3'b000) |-> !ctrl.rf_write)
        else $error("Branch with rf_write high");

endmodule

bind control_unit control_unit_assert control_unit_assert_i (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid)
);

//--- hw/control_unit.sv
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module control_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`RV_XLEN-1:0]     instr,
    input  logic                    instr_valid,
    output rv_ctrl_pkg::ctrl_word_t ctrl,
    output logic                    ctrl_valid
);

    rv_ctrl_pkg::alu_op_t      alu_op;
    rv_ctrl_pkg::operand_sel_t operand_sel;
    rv_ctrl_pkg::mem_size_t    size;
    rv_ctrl_pkg::ctrl_word_t   ctrl_next;
    logic [1:0]                src_regs;
    logic                      rf_write;
    logic                      load_sel;
    logic                      mem_enable;
    logic                      sign_ext;
    logic                      mem_write;
    logic [2:0]                branch_type;
    logic                      jal;
    logic                      jalr;
    logic                      auipc;
    logic                      link_addr;

    exec_decoder exec_decoder_i (
        .instr       (instr),
        .alu_op      (alu_op),
        .operand_sel (operand_sel),
        .src_regs    (src_regs),
        .rf_write    (rf_write)
    );

    mem_decoder mem_decoder_i (
        .instr      (instr),
        .load_sel   (load_sel),
        .size       (size),
        .mem_enable (mem_enable),
        .sign_ext   (sign_ext),
        .mem_write  (mem_write)
    );

    flow_decoder flow_decoder_i (
        .instr       (instr),
        .branch_type (branch_type),
        .jal         (jal),
        .jalr        (jalr),
        .auipc       (auipc),
        .link_addr   (link_addr)
    );

    // Decoders already zero their fields on unknown encodings
    assign ctrl_next = '{
        src_regs:    src_regs,
        alu_op:      alu_op,
        load_sel:    load_sel,
        rf_write:    rf_write,
        operand_sel: operand_sel,
        branch_type: branch_type,
        size:        size,
        mem_enable:  mem_enable,
        sign_ext:    sign_ext,
        mem_write:   mem_write,
        link_addr:   link_addr,
        auipc:       auipc,
        jalr:        jalr,
        jal:         jal
    };

    // ID stage output register
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl       <= '0;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl       <= ctrl_next;    // Updates even when not valid
            ctrl_valid <= instr_valid;
        end
    end

endmodule

//--- hw/flow_decoder.sv
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module flow_decoder (
    input  logic [`RV_XLEN-1:0] instr,
    output logic [2:0]          branch_type,
    output logic                jal,
    output logic                jalr,
    output logic                auipc,
    output logic                link_addr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       branch_ok;

    assign opcode = instr[`RV_OPCODE_HI:`RV_OPCODE_LO];
    assign funct3 = instr[`RV_FUNCT3_HI:`RV_FUNCT3_LO];

    // 010 and 011 are not branches
    assign branch_ok = funct3 inside {`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT,
                                      `RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BGEU};

    always_comb begin
        branch_type = 3'b000;
        jal         = 1'b0;
        jalr        = 1'b0;
        auipc       = 1'b0;
        link_addr   = 1'b0;
        case (opcode)
            `RV_OP_BRANCH: begin
                if (branch_ok) begin
                    // BEQ moved to 010 so that 000 means no branch
                    branch_type = (funct3 == `RV_F3_BEQ) ? 3'b010 : funct3;
                end
            end
            `RV_OP_JAL: begin
                jal       = 1'b1;
                link_addr = 1'b1;   // PC+4 to rd
            end
            `RV_OP_JALR: begin
                jalr      = 1'b1;
                link_addr = 1'b1;
            end
            `RV_OP_AUIPC: auipc = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- hw/mem_decoder.sv
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module mem_decoder (
    input  logic [`RV_XLEN-1:0]    instr,
    output logic                   load_sel,
    output rv_ctrl_pkg::mem_size_t size,
    output logic                   mem_enable,
    output logic                   sign_ext,
    output logic                   mem_write
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       load_ok;
    logic       store_ok;

    assign opcode = instr[`RV_OPCODE_HI:`RV_OPCODE_LO];
    assign funct3 = instr[`RV_FUNCT3_HI:`RV_FUNCT3_LO];

    assign load_ok  = funct3 inside {`RV_F3_LB, `RV_F3_LH, `RV_F3_LW, `RV_F3_LBU, `RV_F3_LHU};
    assign store_ok = funct3 inside {`RV_F3_SB, `RV_F3_SH, `RV_F3_SW};

    always_comb begin
        load_sel   = 1'b0;
        size       = rv_ctrl_pkg::SIZE_BYTE;
        mem_enable = 1'b0;
        sign_ext   = 1'b0;
        mem_write  = 1'b0;
        case (opcode)
            `RV_OP_LOAD: begin
                if (load_ok) begin
                    load_sel   = 1'b1;  // Write-back from memory
                    mem_enable = 1'b1;
                    size       = rv_ctrl_pkg::mem_size_t'(funct3[1:0]);
                    // Only LB and LH extend the sign
                    sign_ext   = (funct3 == `RV_F3_LB) || (funct3 == `RV_F3_LH);
                end
            end
            `RV_OP_STORE: begin
                if (store_ok) begin
                    mem_enable = 1'b1;
                    mem_write  = 1'b1;
                    size       = rv_ctrl_pkg::mem_size_t'(funct3[1:0]);
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hw/exec_decoder.sv
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module exec_decoder (
    input  logic [`RV_XLEN-1:0]       instr,
    output rv_ctrl_pkg::alu_op_t      alu_op,
    output rv_ctrl_pkg::operand_sel_t operand_sel,
    output logic [1:0]                src_regs,
    output logic                      rf_write
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       arith_ok;  // funct3/funct7 pair is a known ALU op
    logic       load_ok;
    logic       store_ok;
    logic       branch_ok;
    rv_ctrl_pkg::alu_op_t arith_op;

    assign opcode = instr[`RV_OPCODE_HI:`RV_OPCODE_LO];
    assign funct3 = instr[`RV_FUNCT3_HI:`RV_FUNCT3_LO];
    assign funct7 = instr[`RV_FUNCT7_HI:`RV_FUNCT7_LO];

    assign load_ok   = funct3 inside {`RV_F3_LB, `RV_F3_LH, `RV_F3_LW, `RV_F3_LBU, `RV_F3_LHU};
    assign store_ok  = funct3 inside {`RV_F3_SB, `RV_F3_SH, `RV_F3_SW};
    assign branch_ok = funct3 inside {`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT,
                                      `RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BGEU};

    // ALU op shared by OP and OP-IMM
    always_comb begin
        arith_ok = 1'b1;
        arith_op = rv_ctrl_pkg::ALU_PASS;
        case (funct3)
            `RV_F3_ADD: begin
                // OP-IMM holds immediate bits where funct7 would be
                if (opcode == `RV_OP_IMM || funct7 == `RV_F7_BASE) arith_op = rv_ctrl_pkg::ALU_ADD;
                else if (funct7 == `RV_F7_ALT) arith_op = rv_ctrl_pkg::ALU_SUB;
                else arith_ok = 1'b0;
            end
            `RV_F3_SLL:  arith_op = rv_ctrl_pkg::ALU_SLL;
            `RV_F3_SLT:  arith_op = rv_ctrl_pkg::ALU_SLT;
            `RV_F3_SLTU: arith_op = rv_ctrl_pkg::ALU_SLTU;
            `RV_F3_XOR:  arith_op = rv_ctrl_pkg::ALU_XOR;
            `RV_F3_SR: begin
                if (funct7 == `RV_F7_BASE) arith_op = rv_ctrl_pkg::ALU_SRL;
                else if (funct7 == `RV_F7_ALT) arith_op = rv_ctrl_pkg::ALU_SRA;
                else arith_ok = 1'b0;
            end
            `RV_F3_OR:   arith_op = rv_ctrl_pkg::ALU_OR;
            `RV_F3_AND:  arith_op = rv_ctrl_pkg::ALU_AND;
            default:     arith_ok = 1'b0;
        endcase
    end

    always_comb begin
        alu_op      = rv_ctrl_pkg::ALU_PASS;
        operand_sel = rv_ctrl_pkg::OPSEL_REG;
        src_regs    = 2'b00;
        rf_write    = 1'b0;
        case (opcode)
            `RV_OP_IMM: begin
                if (arith_ok) begin
                    alu_op      = arith_op;
                    operand_sel = rv_ctrl_pkg::OPSEL_IMM_I;
                    src_regs    = 2'b01;
                    rf_write    = 1'b1;
                end
            end
            `RV_OP_REG: begin
                if (arith_ok) begin
                    alu_op   = arith_op;
                    src_regs = 2'b10;
                    rf_write = 1'b1;
                end
            end
            `RV_OP_LUI: begin
                operand_sel = rv_ctrl_pkg::OPSEL_IMM_U; // ALU passes the immediate
                rf_write    = 1'b1;
            end
            `RV_OP_AUIPC: begin
                alu_op      = rv_ctrl_pkg::ALU_ADD;
                operand_sel = rv_ctrl_pkg::OPSEL_IMM_U;
                rf_write    = 1'b1;
            end
            `RV_OP_LOAD: begin
                if (load_ok) begin
                    alu_op      = rv_ctrl_pkg::ALU_ADD;     // Address calc
                    operand_sel = rv_ctrl_pkg::OPSEL_IMM_I;
                    src_regs    = 2'b01;
                    rf_write    = 1'b1;
                end
            end
            `RV_OP_STORE: begin
                if (store_ok) begin
                    alu_op      = rv_ctrl_pkg::ALU_ADD;
                    operand_sel = rv_ctrl_pkg::OPSEL_IMM_S;
                    src_regs    = 2'b10;                    // Base plus store data
                end
            end
            `RV_OP_BRANCH: begin
                if (branch_ok) begin
                    alu_op   = rv_ctrl_pkg::ALU_SUB;        // Compare rs1 and rs2
                    src_regs = 2'b10;
                end
            end
            `RV_OP_JAL:  rf_write = 1'b1;                   // Link register only
            `RV_OP_JALR: begin
                alu_op      = rv_ctrl_pkg::ALU_JUMP;
                operand_sel = rv_ctrl_pkg::OPSEL_IMM_I;
                src_regs    = 2'b01;
                rf_write    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // ALU operation codes as the EX stage expects them
    typedef enum logic [3:0] {
        ALU_PASS = 4'b0000, // Operand B straight through
        ALU_ADD  = 4'b0010,
        ALU_SUB  = 4'b0011,
        ALU_JUMP = 4'b0100, // JALR target
        ALU_SLL  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SRA  = 4'b0111,
        ALU_SLT  = 4'b1000,
        ALU_SLTU = 4'b1001,
        ALU_AND  = 4'b1010,
        ALU_OR   = 4'b1011,
        ALU_XOR  = 4'b1100
    } alu_op_t;

    // Same code as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    // S2..S0, source of the second ALU operand
    typedef enum logic [2:0] {
        OPSEL_REG   = 3'b000,
        OPSEL_IMM_I = 3'b001,
        OPSEL_IMM_S = 3'b010,
        OPSEL_IMM_U = 3'b011
    } operand_sel_t;

    // ID stage control word, bit 22 down to bit 0
    typedef struct packed {
        logic [1:0]   src_regs;    // [22:21]
        alu_op_t      alu_op;      // [20:17]
        logic         load_sel;    // 16
        logic         rf_write;    // 15
        operand_sel_t operand_sel; // [14:12]
        logic [2:0]   branch_type; // [11:9]
        mem_size_t    size;        // [8:7]
        logic         mem_enable;  // 6
        logic         sign_ext;    // 5
        logic         mem_write;   // 4
        logic         link_addr;   // 3
        logic         auipc;       // 2
        logic         jalr;        // 1
        logic         jal;         // 0
    } ctrl_word_t;

endpackage

//--- hw/rv_ctrl_defines.svh
`ifndef RV_CTRL_DEFINES_SVH
`define RV_CTRL_DEFINES_SVH

`define RV_XLEN 32

// Major opcodes, bits [6:0]
`define RV_OP_IMM    7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_REG    7'b0110011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111

// funct7 picks SUB and the arithmetic right shift
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

// Instruction field bounds
`define RV_OPCODE_HI 6
`define RV_OPCODE_LO 0
`define RV_FUNCT3_HI 14
`define RV_FUNCT3_LO 12
`define RV_FUNCT7_HI 31
`define RV_FUNCT7_LO 25

// funct3 of the integer ALU group, shared by OP and OP-IMM
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101 // SRL or SRA by funct7
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// Loads and stores
`define RV_F3_LB  3'b000
`define RV_F3_LH  3'b001
`define RV_F3_LW  3'b010
`define RV_F3_LBU 3'b100
`define RV_F3_LHU 3'b101
`define RV_F3_SB  3'b000
`define RV_F3_SH  3'b001
`define RV_F3_SW  3'b010

// Conditional branches
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif
